// ==== hw/adc_capture_pkg.sv ====
`default_nettype none

package adc_capture_pkg;

    localparam int SAMPLE_W   = 12;
    localparam int WORD_W     = 36;  // three samples per slow word
    localparam int FAST_DEPTH = 64;
    localparam int SLOW_DEPTH = 64;
    localparam int WB_ADR_W   = 3;
    localparam int WB_DAT_W   = 32;

    // word addresses on the host bus
    localparam logic [WB_ADR_W-1:0] REG_CTRL        = 3'd0;
    localparam logic [WB_ADR_W-1:0] REG_PRESAMPLES  = 3'd1;
    localparam logic [WB_ADR_W-1:0] REG_MAX_SAMPLES = 3'd2;
    localparam logic [WB_ADR_W-1:0] REG_DOWNSAMPLE  = 3'd3;
    localparam logic [WB_ADR_W-1:0] REG_STATUS      = 3'd4;
    localparam logic [WB_ADR_W-1:0] REG_DATA        = 3'd5;

    typedef enum logic [2:0] {
        IDLE,
        PRESAMP_FILLING,
        PRESAMP_FULL,
        TRIGGERED,
        DONE
    } capture_state_e;

    typedef struct packed {
        logic [5:0] presamples;   // at most FAST_DEPTH-1
        logic [7:0] max_samples;  // total, presamples included
        logic [7:0] downsample;
        logic       low_res;
    } capture_cfg_t;

    typedef struct packed {
        logic downsample_error;
        logic presamp_error;
        logic fast_overflow;
        logic slow_underflow;
    } capture_err_t;

endpackage

`default_nettype wire

// ==== hw/sync_fifo.sv ====
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 12,
    parameter int DEPTH = 64  // power of two
) (
    input  wire              clk_i,
    input  wire              rst_i,
    input  wire              flush_i,
    input  wire              wr_i,
    input  wire  [WIDTH-1:0] din_i,
    input  wire              rd_i,
    output logic [WIDTH-1:0] dout_o,
    output logic             full_o,
    output logic             empty_o,
    output logic             overflow_o,
    output logic             underflow_o
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW:0]      wr_ptr;  // extra msb tells full from empty
    logic [AW:0]      rd_ptr;
    logic             do_wr;
    logic             do_rd;

    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_wr = wr_i && !full_o;
    assign do_rd = rd_i && !empty_o;

    assign overflow_o  = wr_i && full_o;
    assign underflow_o = rd_i && empty_o;

    assign dout_o = mem[rd_ptr[AW-1:0]];  // head word always visible

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_wr && !flush_i) begin
            mem[wr_ptr[AW-1:0]] <= din_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/capture_ctrl.sv ====
`default_nettype none

module capture_ctrl (
    input  wire                           adc_sampleclk,
    input  wire                           fifo_rst,
    input  wire adc_capture_pkg::capture_cfg_t cfg_i,
    input  wire                           arm_i,
    input  wire                           adc_capture_go_i,
    output logic                          fast_wr_o,
    output logic                          presample_drain_o,
    output logic                          drain_en_o,
    input  wire                           fast_empty_i,
    input  wire                           fast_full_i,
    output logic                          adc_capture_stop_o,
    output logic                          downsample_error_o,
    output logic                          presamp_error_o
);

    adc_capture_pkg::capture_state_e state;

    logic       armed;      // waiting in IDLE for the trigger
    logic [5:0] pre_cnt;
    logic [8:0] wr_cnt;     // samples kept for this capture
    logic [8:0] wr_next;
    logic [8:0] target;
    logic [7:0] ds_cnt;
    logic       ds_tick;
    logic       capturing;

    // total rounded up to whole packed words
    assign target = 9'(((10'(cfg_i.max_samples) + 10'd2) / 10'd3) * 10'd3);

    assign ds_tick = (ds_cnt == 8'd0);

    assign capturing = (state == adc_capture_pkg::PRESAMP_FILLING)
                    || (state == adc_capture_pkg::PRESAMP_FULL)
                    || ((state == adc_capture_pkg::TRIGGERED) && (wr_cnt < target))
                    || ((state == adc_capture_pkg::IDLE) && armed && adc_capture_go_i);

    assign fast_wr_o = capturing && ds_tick && !arm_i;

    // keep the fifo at the presample count, but not on the trigger sample
    assign presample_drain_o = fast_wr_o && (state == adc_capture_pkg::PRESAMP_FULL)
                            && !adc_capture_go_i;

    // packer takes the oldest presample on the trigger edge
    assign drain_en_o = (state == adc_capture_pkg::TRIGGERED)
                     || (state == adc_capture_pkg::DONE)
                     || ((state == adc_capture_pkg::PRESAMP_FULL) && adc_capture_go_i);

    assign presamp_error_o = (state == adc_capture_pkg::PRESAMP_FILLING) && adc_capture_go_i;

    assign downsample_error_o = arm_i && (cfg_i.downsample != 8'd0)
                             && (cfg_i.presamples != 6'd0);

    assign wr_next = wr_cnt + 9'(fast_wr_o && !fast_full_i);  // dropped samples not counted

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || arm_i) begin
            ds_cnt <= '0;
        end else if (ds_cnt == cfg_i.downsample) begin
            ds_cnt <= '0;
        end else begin
            ds_cnt <= ds_cnt + 8'd1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            state              <= adc_capture_pkg::IDLE;
            armed              <= 1'b0;
            pre_cnt            <= '0;
            wr_cnt             <= '0;
            adc_capture_stop_o <= 1'b0;
        end else if (arm_i) begin
            pre_cnt            <= '0;
            wr_cnt             <= '0;
            adc_capture_stop_o <= 1'b0;
            armed              <= (cfg_i.presamples == 6'd0);
            state              <= (cfg_i.presamples != 6'd0) ? adc_capture_pkg::PRESAMP_FILLING
                                                             : adc_capture_pkg::IDLE;
        end else begin
            case (state)
                adc_capture_pkg::IDLE: begin
                    if (armed && adc_capture_go_i) begin
                        armed  <= 1'b0;
                        wr_cnt <= wr_next;
                        state  <= adc_capture_pkg::TRIGGERED;
                    end
                end
                adc_capture_pkg::PRESAMP_FILLING: begin
                    if (adc_capture_go_i) begin  // early trigger leaves fewer presamples
                        wr_cnt <= 9'(pre_cnt) + wr_next;
                        state  <= adc_capture_pkg::TRIGGERED;
                    end else if (fast_wr_o) begin
                        pre_cnt <= pre_cnt + 6'd1;
                        if (pre_cnt + 6'd1 == cfg_i.presamples) begin
                            state <= adc_capture_pkg::PRESAMP_FULL;
                        end
                    end
                end
                adc_capture_pkg::PRESAMP_FULL: begin
                    if (adc_capture_go_i) begin
                        wr_cnt <= 9'(pre_cnt) + wr_next;
                        state  <= adc_capture_pkg::TRIGGERED;
                    end
                end
                adc_capture_pkg::TRIGGERED: begin
                    wr_cnt <= wr_next;
                    if (wr_next >= target) begin
                        adc_capture_stop_o <= 1'b1;
                        state              <= adc_capture_pkg::DONE;
                    end
                end
                adc_capture_pkg::DONE: begin
                    if (fast_empty_i) begin  // packer has taken everything
                        state <= adc_capture_pkg::IDLE;
                    end
                end
                default: state <= adc_capture_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/sample_packer.sv ====
`default_nettype none

module sample_packer (
    input  wire                                  adc_sampleclk,
    input  wire                                  fifo_rst,
    input  wire                                  flush_i,
    input  wire                                  drain_en_i,
    input  wire  [adc_capture_pkg::SAMPLE_W-1:0] fast_dout_i,
    input  wire                                  fast_empty_i,
    output logic                                 fast_pop_o,
    input  wire                                  slow_full_i,
    output logic                                 slow_wr_o,
    output logic [adc_capture_pkg::WORD_W-1:0]   slow_din_o
);

    logic [1:0]                            phase;  // samples already held
    logic [2*adc_capture_pkg::SAMPLE_W-1:0] held;

    // back-pressure: stall on a full slow fifo, nothing is dropped
    assign fast_pop_o = drain_en_i && !fast_empty_i && !slow_full_i && !flush_i;

    assign slow_wr_o  = fast_pop_o && (phase == 2'd2);
    assign slow_din_o = {held, fast_dout_i};  // oldest sample on top

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || flush_i) begin
            phase <= 2'd0;
        end else if (fast_pop_o) begin
            phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fast_pop_o) begin
            held <= {held[adc_capture_pkg::SAMPLE_W-1:0], fast_dout_i};
        end
    end

endmodule

`default_nettype wire

// ==== hw/wb_readout.sv ====
`default_nettype none

module wb_readout (
    input  wire                                  adc_sampleclk,
    input  wire                                  fifo_rst,
    input  wire                                  wb_cyc_i,
    input  wire                                  wb_stb_i,
    input  wire                                  wb_we_i,
    input  wire  [adc_capture_pkg::WB_ADR_W-1:0] wb_adr_i,
    input  wire  [adc_capture_pkg::WB_DAT_W-1:0] wb_dat_i,
    output logic [adc_capture_pkg::WB_DAT_W-1:0] wb_dat_o,
    output logic                                 wb_ack_o,
    output adc_capture_pkg::capture_cfg_t        cfg_o,
    output logic                                 arm_o,
    input  wire adc_capture_pkg::capture_err_t   err_i,
    input  wire                                  capture_stop_i,
    input  wire  [adc_capture_pkg::WORD_W-1:0]   slow_dout_i,
    input  wire                                  slow_empty_i,
    output logic                                 slow_pop_o,
    output logic                                 error_flag_o
);

    adc_capture_pkg::capture_err_t sticky;

    logic                                 req;
    logic                                 wr_req;
    logic                                 data_rd;
    logic                                 clr;
    logic                                 last_byte;
    logic [3:0]                           byte_ptr;  // 0..2 low-res, 0..8 hi-res
    logic [3:0]                           nib;       // low nibble left over from word one
    logic [7:0]                           rd_byte;
    logic [adc_capture_pkg::WB_DAT_W-1:0] rd_mux;

    assign req     = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign wr_req  = req && wb_we_i;
    assign data_rd = req && !wb_we_i && (wb_adr_i == adc_capture_pkg::REG_DATA);
    assign arm_o   = wr_req && (wb_adr_i == adc_capture_pkg::REG_CTRL) && wb_dat_i[0];
    assign clr     = wr_req && (wb_adr_i == adc_capture_pkg::REG_CTRL) && wb_dat_i[1];

    assign last_byte = cfg_o.low_res ? (byte_ptr == 4'd2)
                                     : ((byte_ptr == 4'd3) || (byte_ptr == 4'd8));

    // popping an empty fifo raises its underflow strobe
    assign slow_pop_o   = data_rd && (slow_empty_i || last_byte);
    assign error_flag_o = |sticky;

    always_comb begin
        rd_byte = 8'h00;
        if (!slow_empty_i) begin
            if (cfg_o.low_res) begin
                case (byte_ptr)
                    4'd0:    rd_byte = slow_dout_i[35:28];
                    4'd1:    rd_byte = slow_dout_i[23:16];
                    4'd2:    rd_byte = slow_dout_i[11:4];
                    default: rd_byte = 8'h00;
                endcase
            end else begin
                case (byte_ptr)
                    4'd0:    rd_byte = slow_dout_i[35:28];
                    4'd1:    rd_byte = slow_dout_i[27:20];
                    4'd2:    rd_byte = slow_dout_i[19:12];
                    4'd3:    rd_byte = slow_dout_i[11:4];
                    4'd4:    rd_byte = {nib, slow_dout_i[35:32]};
                    4'd5:    rd_byte = slow_dout_i[31:24];
                    4'd6:    rd_byte = slow_dout_i[23:16];
                    4'd7:    rd_byte = slow_dout_i[15:8];
                    4'd8:    rd_byte = slow_dout_i[7:0];
                    default: rd_byte = 8'h00;
                endcase
            end
        end
    end

    always_comb begin
        rd_mux = '0;
        case (wb_adr_i)
            adc_capture_pkg::REG_PRESAMPLES:  rd_mux[5:0] = cfg_o.presamples;
            adc_capture_pkg::REG_MAX_SAMPLES: rd_mux[7:0] = cfg_o.max_samples;
            adc_capture_pkg::REG_DOWNSAMPLE:  rd_mux[7:0] = cfg_o.downsample;
            adc_capture_pkg::REG_STATUS: begin
                rd_mux[7:0] = {sticky.slow_underflow, sticky.fast_overflow,
                               sticky.presamp_error, sticky.downsample_error,
                               1'b0, cfg_o.low_res, slow_empty_i, capture_stop_i};
            end
            adc_capture_pkg::REG_DATA:        rd_mux[7:0] = rd_byte;
            default:                          rd_mux = '0;
        endcase
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            wb_ack_o <= 1'b0;
            cfg_o    <= '0;
            sticky   <= '0;
            byte_ptr <= 4'd0;
        end else begin
            wb_ack_o <= req;
            // new strobes win over a clear in the same cycle
            sticky <= (arm_o || clr) ? err_i : adc_capture_pkg::capture_err_t'(sticky | err_i);
            if (wr_req) begin
                case (wb_adr_i)
                    adc_capture_pkg::REG_CTRL:        cfg_o.low_res     <= wb_dat_i[2];
                    adc_capture_pkg::REG_PRESAMPLES:  cfg_o.presamples  <= wb_dat_i[5:0];
                    adc_capture_pkg::REG_MAX_SAMPLES: cfg_o.max_samples <= wb_dat_i[7:0];
                    adc_capture_pkg::REG_DOWNSAMPLE:  cfg_o.downsample  <= wb_dat_i[7:0];
                    default: ;
                endcase
            end
            if (arm_o) begin
                byte_ptr <= 4'd0;  // fifos are flushed too
            end else if (data_rd && !slow_empty_i) begin
                if ((cfg_o.low_res && byte_ptr == 4'd2) || byte_ptr == 4'd8) begin
                    byte_ptr <= 4'd0;
                end else begin
                    byte_ptr <= byte_ptr + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (req) begin
            wb_dat_o <= rd_mux;  // held while ack is high
        end
        if (data_rd && !slow_empty_i && !cfg_o.low_res && byte_ptr == 4'd3) begin
            nib <= slow_dout_i[3:0];
        end
    end

endmodule

`default_nettype wire

// ==== hw/adc_capture_top.sv ====
`default_nettype none

module adc_capture_top (
    input  wire                                  adc_sampleclk,
    input  wire                                  fifo_rst,
    input  wire  [adc_capture_pkg::SAMPLE_W-1:0] adc_datain_i,
    input  wire                                  adc_capture_go_i,
    output logic                                 adc_capture_stop_o,
    input  wire                                  wb_cyc_i,
    input  wire                                  wb_stb_i,
    input  wire                                  wb_we_i,
    input  wire  [adc_capture_pkg::WB_ADR_W-1:0] wb_adr_i,
    input  wire  [adc_capture_pkg::WB_DAT_W-1:0] wb_dat_i,
    output logic [adc_capture_pkg::WB_DAT_W-1:0] wb_dat_o,
    output logic                                 wb_ack_o,
    output logic                                 error_flag_o
);

    adc_capture_pkg::capture_cfg_t cfg;
    adc_capture_pkg::capture_err_t cap_err;

    logic                                arm;
    logic                                fast_wr;
    logic                                fast_rd;
    logic                                presample_drain;
    logic                                drain_en;
    logic                                fast_pop;
    logic [adc_capture_pkg::SAMPLE_W-1:0] fast_dout;
    logic                                fast_full;
    logic                                fast_empty;
    logic                                fast_overflow;
    logic                                ds_err;
    logic                                pre_err;
    logic                                slow_wr;
    logic                                slow_pop;
    logic [adc_capture_pkg::WORD_W-1:0]  slow_din;
    logic [adc_capture_pkg::WORD_W-1:0]  slow_dout;
    logic                                slow_full;
    logic                                slow_empty;
    logic                                slow_underflow;

    assign fast_rd = presample_drain || fast_pop;

    assign cap_err = '{downsample_error: ds_err, presamp_error: pre_err,
                       fast_overflow: fast_overflow, slow_underflow: slow_underflow};

    capture_ctrl ctrl_i (
        .adc_sampleclk, .fifo_rst, .cfg_i(cfg), .arm_i(arm), .adc_capture_go_i,
        .fast_wr_o(fast_wr), .presample_drain_o(presample_drain), .drain_en_o(drain_en),
        .fast_empty_i(fast_empty), .fast_full_i(fast_full), .adc_capture_stop_o,
        .downsample_error_o(ds_err), .presamp_error_o(pre_err)
    );

    sync_fifo #(.WIDTH(adc_capture_pkg::SAMPLE_W), .DEPTH(adc_capture_pkg::FAST_DEPTH)) fast_i (
        .clk_i(adc_sampleclk), .rst_i(fifo_rst), .flush_i(arm), .wr_i(fast_wr),
        .din_i(adc_datain_i), .rd_i(fast_rd), .dout_o(fast_dout), .full_o(fast_full),
        .empty_o(fast_empty), .overflow_o(fast_overflow), .underflow_o()
    );

    sample_packer packer_i (
        .adc_sampleclk, .fifo_rst, .flush_i(arm), .drain_en_i(drain_en),
        .fast_dout_i(fast_dout), .fast_empty_i(fast_empty), .fast_pop_o(fast_pop),
        .slow_full_i(slow_full), .slow_wr_o(slow_wr), .slow_din_o(slow_din)
    );

    sync_fifo #(.WIDTH(adc_capture_pkg::WORD_W), .DEPTH(adc_capture_pkg::SLOW_DEPTH)) slow_i (
        .clk_i(adc_sampleclk), .rst_i(fifo_rst), .flush_i(arm), .wr_i(slow_wr),
        .din_i(slow_din), .rd_i(slow_pop), .dout_o(slow_dout), .full_o(slow_full),
        .empty_o(slow_empty), .overflow_o(), .underflow_o(slow_underflow)
    );

    wb_readout readout_i (
        .adc_sampleclk, .fifo_rst, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
        .wb_dat_o, .wb_ack_o, .cfg_o(cfg), .arm_o(arm), .err_i(cap_err),
        .capture_stop_i(adc_capture_stop_o), .slow_dout_i(slow_dout),
        .slow_empty_i(slow_empty), .slow_pop_o(slow_pop), .error_flag_o
    );

endmodule

`default_nettype wire

// ==== verification/adc_capture_tb.sv ====
`default_nettype none

module adc_capture_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TEST_LEN     = 15 * 192;       // runs times the longest capture
    localparam int WATCHDOG_CYC = TEST_LEN * 50;

    logic                                 adc_sampleclk = 1'b0;
    logic                                 fifo_rst;
    logic [adc_capture_pkg::SAMPLE_W-1:0] adc_datain;
    logic                                 capture_go;
    logic                                 capture_stop;
    logic                                 wb_cyc;
    logic                                 wb_stb;
    logic                                 wb_we;
    logic [adc_capture_pkg::WB_ADR_W-1:0] wb_adr;
    logic [adc_capture_pkg::WB_DAT_W-1:0] wb_wdata;
    logic [adc_capture_pkg::WB_DAT_W-1:0] wb_rdata;
    logic                                 wb_ack;
    logic                                 error_flag;
    logic [31:0]                          lcg_state;
    logic [7:0]                           exp_q[$];  // expected DATA bytes

    adc_capture_top dut_i (
        .adc_sampleclk, .fifo_rst, .adc_datain_i(adc_datain), .adc_capture_go_i(capture_go),
        .adc_capture_stop_o(capture_stop), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
        .wb_we_i(wb_we), .wb_adr_i(wb_adr), .wb_dat_i(wb_wdata), .wb_dat_o(wb_rdata),
        .wb_ack_o(wb_ack), .error_flag_o(error_flag)
    );

    always #5 adc_sampleclk = ~adc_sampleclk;

    always @(negedge adc_sampleclk) begin
        adc_datain <= adc_datain + 1'b1;  // free-running ramp that wraps at 4096
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int rand_below(input int n);
        lcg_state = lcg_next(lcg_state);
        return int'(lcg_state[30:16]) % n;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("TEST FAILED");
            $fatal(1, "Mismatch %s: exp %h got %h", name, exp, got);
        end
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
        @(negedge adc_sampleclk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_wdata = data;
        do begin
            @(negedge adc_sampleclk);
        end while (!wb_ack);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
        @(negedge adc_sampleclk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        do begin
            @(negedge adc_sampleclk);
        end while (!wb_ack);
        data   = wb_rdata;  // valid while ack is high
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    // arm, trigger after pre+delay cycles, then read back and compare every byte
    task automatic run_capture(input logic low_res, input int pre, input int max_s,
                               input int ds, input int delay);
        int          n;
        int          skip;
        int          i;
        logic [11:0] trig_val;
        logic [11:0] smp;
        logic [11:0] prev;
        logic [31:0] st;
        logic [31:0] rd;
        n = ((max_s + 2) / 3) * 3;  // whole packed words
        wb_write(adc_capture_pkg::REG_PRESAMPLES, pre);
        wb_write(adc_capture_pkg::REG_MAX_SAMPLES, max_s);
        wb_write(adc_capture_pkg::REG_DOWNSAMPLE, ds);
        wb_read(adc_capture_pkg::REG_PRESAMPLES, rd);
        check_eq("wb_dat_o presamples", pre, rd);
        wb_read(adc_capture_pkg::REG_MAX_SAMPLES, rd);
        check_eq("wb_dat_o max_samples", max_s, rd);
        wb_read(adc_capture_pkg::REG_DOWNSAMPLE, rd);
        check_eq("wb_dat_o downsample", ds, rd);
        wb_write(adc_capture_pkg::REG_CTRL, {29'd0, low_res, 2'b01});
        repeat (pre + delay) @(negedge adc_sampleclk);
        capture_go = 1'b1;
        @(posedge adc_sampleclk);
        trig_val = adc_datain;  // ramp value on the trigger edge
        @(negedge adc_sampleclk);
        capture_go = 1'b0;
        // ticks every ds+1 edges from the edge after arm
        skip = ((pre + delay + ds) / (ds + 1)) * (ds + 1) - (pre + delay);
        exp_q.delete();
        for (i = 0; i < n; i++) begin
            smp = 12'(trig_val - pre + skip + i * (ds + 1));
            if (low_res) begin
                exp_q.push_back(smp[11:4]);
            end else if (i % 2 == 0) begin
                exp_q.push_back(smp[11:4]);
                prev = smp;
            end else begin
                exp_q.push_back({prev[3:0], smp[11:8]});  // two samples per 3 bytes
                exp_q.push_back(smp[7:0]);
            end
        end
        do begin
            wb_read(adc_capture_pkg::REG_STATUS, st);
        end while (!st[0]);
        for (i = 0; i < exp_q.size(); i++) begin
            do begin
                wb_read(adc_capture_pkg::REG_STATUS, st);
            end while (st[1]);  // wait for a packed word
            wb_read(adc_capture_pkg::REG_DATA, rd);
            check_eq($sformatf("wb_dat_o byte %0d", i), {24'd0, exp_q[i]}, rd);
        end
        wb_read(adc_capture_pkg::REG_STATUS, st);
        check_eq("status stop", 32'd1, st[0]);
        check_eq("status empty", 32'd1, st[1]);
        check_eq("status low_res", {31'd0, low_res}, st[2]);
        check_eq("status errors", 32'd0, st[7:4]);
        check_eq("adc_capture_stop_o", 32'd1, capture_stop);
    endtask

    initial begin
        int          pre;
        int          len;
        int          ds;
        logic [31:0] st;
        logic [31:0] rd;
        fifo_rst      = 1'b1;
        capture_go    = 1'b0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_wdata      = '0;
        lcg_state     = 32'h9543;
        adc_datain    = 12'(rand_below(4096));
        repeat (8) @(negedge adc_sampleclk);
        fifo_rst = 1'b0;
        check_eq("adc_capture_stop_o", 32'd0, capture_stop);
        check_eq("error_flag_o", 32'd0, error_flag);
        check_eq("wb_ack_o", 32'd0, wb_ack);
        wb_read(adc_capture_pkg::REG_STATUS, st);
        check_eq("status after reset", 32'h2, st);  // slow fifo empty only

        repeat (3) begin
            len = 1 + rand_below(150);
            run_capture(1'b1, 0, len, 0, rand_below(20));
        end
        repeat (3) begin
            pre = 1 + rand_below(63);
            len = pre + 2 + rand_below(100);
            run_capture(1'b1, pre, len, 0, rand_below(16));
        end
        repeat (3) begin
            pre = rand_below(8);
            len = 6 * (2 + rand_below(29));
            run_capture(1'b0, pre, len, 0, rand_below(16));
        end
        repeat (3) begin
            ds  = 1 + rand_below(4);
            len = 6 * (1 + rand_below(20));
            run_capture(1'b0, 0, len, ds, rand_below(16));
        end
        run_capture(1'b0, 0, 192, 0, 3);  // slow fifo full before the first read

        wb_read(adc_capture_pkg::REG_DATA, rd);  // one byte past the end
        check_eq("wb_dat_o empty read", 32'd0, rd);
        check_eq("error_flag_o", 32'd1, error_flag);
        wb_read(adc_capture_pkg::REG_STATUS, st);
        check_eq("status underflow bit", 32'd1, st[7]);
        wb_write(adc_capture_pkg::REG_CTRL, 32'h2);
        wb_read(adc_capture_pkg::REG_STATUS, st);
        check_eq("status errors after clear", 32'd0, st[7:4]);
        check_eq("error_flag_o", 32'd0, error_flag);

        pre = 2 + rand_below(10);
        wb_write(adc_capture_pkg::REG_PRESAMPLES, pre);
        wb_write(adc_capture_pkg::REG_MAX_SAMPLES, 30);
        wb_write(adc_capture_pkg::REG_DOWNSAMPLE, 0);
        wb_write(adc_capture_pkg::REG_CTRL, 32'h5);
        capture_go = 1'b1;  // trigger while presamples still fill
        do begin
            wb_read(adc_capture_pkg::REG_STATUS, st);
        end while (!st[0]);
        capture_go = 1'b0;
        check_eq("status presample error bit", 32'd1, st[5]);

        wb_write(adc_capture_pkg::REG_PRESAMPLES, 3);
        wb_write(adc_capture_pkg::REG_DOWNSAMPLE, 2);
        wb_write(adc_capture_pkg::REG_CTRL, 32'h5);
        wb_read(adc_capture_pkg::REG_STATUS, st);
        check_eq("status downsample error bit", 32'd1, st[4]);
        check_eq("status presample error bit", 32'd0, st[5]);  // arm cleared it
        wb_write(adc_capture_pkg::REG_CTRL, 32'h6);
        wb_read(adc_capture_pkg::REG_STATUS, st);
        check_eq("status errors after clear", 32'd0, st[7:4]);
        check_eq("error_flag_o", 32'd0, error_flag);

        $display("TEST PASSED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge adc_sampleclk);
        $display("TEST FAILED");
        $fatal(1, "timeout: the test did not finish within %0d clock cycles", WATCHDOG_CYC);
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/adc_capture_pkg.sv
hw/sync_fifo.sv
hw/capture_ctrl.sv
hw/sample_packer.sv
hw/wb_readout.sv
hw/adc_capture_top.sv
verification/adc_capture_tb.sv

// ==== Bender.yml ====
package:
  name: adc_capture

sources:
  - hw/adc_capture_pkg.sv
  - hw/sync_fifo.sv
  - hw/capture_ctrl.sv
  - hw/sample_packer.sv
  - hw/wb_readout.sv
  - hw/adc_capture_top.sv
  - target: test
    files:
      - verification/adc_capture_tb.sv
